/* hw/cache_geom_pkg.sv */
package cache_geom_pkg;

	// data and address widths seen on both buses
	typedef logic [31:0] word_t;
	typedef logic [31:0] addr_t;
	typedef logic [3:0]  sel_t;

	// default geometry
	// 4 ways of 64 sets of 8 words gives 8 KiB
	localparam int WAYS_DEFAULT       = 4;
	localparam int LINE_WORDS_DEFAULT = 8;
	localparam int SETS_DEFAULT       = 64;

	// controller FSM
	typedef enum logic [2:0] {
		INVALIDATING,
		IDLE,
		LOOKUP,
		WAIT_WB,
		REFILL,
		RESPOND
	} ctrl_state_t;

endpackage

/* hw/wb_bus_pkg.sv */
package wb_bus_pkg;

	// one-hot grant of the shared memory port
	typedef logic [1:0] grant_t;

	// write-back engine wins when both request
	localparam grant_t GRANT_NONE   = 2'b00;
	localparam grant_t GRANT_WB     = 2'b01;
	localparam grant_t GRANT_REFILL = 2'b10;

endpackage

/* hw/wb_arbiter.sv */
`timescale 1ns/1ps

module wb_arbiter (
	input  logic                  i_clk,
	input  logic                  i_rst,
	input  logic                  i_wb_cyc,
	input  logic                  i_wb_stb,
	input  logic                  i_wb_we,
	input  cache_geom_pkg::sel_t  i_wb_sel,
	input  cache_geom_pkg::addr_t i_wb_adr,
	input  cache_geom_pkg::word_t i_wb_dat,
	input  logic                  i_rf_cyc,
	input  logic                  i_rf_stb,
	input  cache_geom_pkg::addr_t i_rf_adr,
	input  logic                  i_mem_ack,
	output wb_bus_pkg::grant_t    o_grant,
	output logic                  o_mem_cyc,
	output logic                  o_mem_stb,
	output logic                  o_mem_we,
	output cache_geom_pkg::sel_t  o_mem_sel,
	output cache_geom_pkg::addr_t o_mem_adr,
	output cache_geom_pkg::word_t o_mem_dat,
	output logic                  o_ack_wb,
	output logic                  o_ack_refill
);

	wb_bus_pkg::grant_t r_grant;
	logic               w_wb_own, w_rf_own;

	assign w_wb_own = r_grant[0];
	assign w_rf_own = r_grant[1];

	// grant stays until its owner ends the bus cycle
	always_ff @(posedge i_clk) begin
		if (i_rst)
			r_grant <= wb_bus_pkg::GRANT_NONE;
		else if (r_grant == wb_bus_pkg::GRANT_NONE) begin
			if (i_wb_cyc)
				r_grant <= wb_bus_pkg::GRANT_WB;
			else if (i_rf_cyc)
				r_grant <= wb_bus_pkg::GRANT_REFILL;
		end else if ((w_wb_own && !i_wb_cyc) || (w_rf_own && !i_rf_cyc))
			r_grant <= wb_bus_pkg::GRANT_NONE;
	end

	assign o_grant      = r_grant;
	assign o_mem_cyc    = (w_wb_own && i_wb_cyc) || (w_rf_own && i_rf_cyc);
	assign o_mem_stb    = (w_wb_own && i_wb_stb) || (w_rf_own && i_rf_stb);
	assign o_mem_we     = w_wb_own && i_wb_we;
	assign o_mem_sel    = w_wb_own ? i_wb_sel : 4'hf;
	assign o_mem_adr    = w_wb_own ? i_wb_adr : i_rf_adr;
	assign o_mem_dat    = i_wb_dat;
	assign o_ack_wb     = w_wb_own && i_mem_ack;
	assign o_ack_refill = w_rf_own && i_mem_ack;

	// grant still held when the memory answers
	a_ack_routed: assert property (@(posedge i_clk) disable iff (i_rst)
		i_mem_ack |-> (o_ack_wb || o_ack_refill));

endmodule

/* hw/line_writeback.sv */
`timescale 1ns/1ps

module line_writeback #(
	parameter int P_LINE_WORDS = 8
) (
	input  logic                  i_clk,
	input  logic                  i_rst,
	input  logic                  i_start,
	input  cache_geom_pkg::addr_t i_victim_adr,
	input  cache_geom_pkg::word_t i_victim_line [P_LINE_WORDS],
	input  logic                  i_ack,
	output logic                  o_cyc,
	output logic                  o_stb,
	output logic                  o_we,
	output cache_geom_pkg::sel_t  o_sel,
	output cache_geom_pkg::addr_t o_adr,
	output cache_geom_pkg::word_t o_dat,
	output logic                  o_busy
);

	localparam int OFF_W = $clog2(P_LINE_WORDS);

	logic                  r_busy;
	logic [OFF_W-1:0]      r_cnt;
	cache_geom_pkg::addr_t r_base;
	cache_geom_pkg::word_t r_buf [P_LINE_WORDS];

	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			r_busy <= 1'b0;
			r_cnt  <= '0;
		end else if (i_start) begin
			r_busy <= 1'b1;
			r_cnt  <= '0;
		end else if (r_busy && i_ack) begin
			r_cnt <= r_cnt + 1'b1;
			if (r_cnt == OFF_W'(P_LINE_WORDS - 1))
				r_busy <= 1'b0;
		end
	end

	// one-line victim buffer
	always_ff @(posedge i_clk) begin
		if (i_start) begin
			r_base <= i_victim_adr;
			r_buf  <= i_victim_line;
		end
	end

	assign o_cyc  = r_busy;
	assign o_stb  = r_busy;
	assign o_we   = r_busy;
	assign o_sel  = 4'hf;
	assign o_adr  = r_base | {{(30-OFF_W){1'b0}}, r_cnt, 2'b00};
	assign o_dat  = r_buf[r_cnt];
	assign o_busy = r_busy;

endmodule

/* hw/line_refill.sv */
`timescale 1ns/1ps

module line_refill #(
	parameter int P_LINE_WORDS = 8
) (
	input  logic                            i_clk,
	input  logic                            i_rst,
	input  logic                            i_start,
	input  cache_geom_pkg::addr_t           i_line_adr,
	input  logic                            i_pend_we,
	input  logic [$clog2(P_LINE_WORDS)-1:0] i_pend_off,
	input  cache_geom_pkg::sel_t            i_pend_sel,
	input  cache_geom_pkg::word_t           i_pend_dat,
	input  logic                            i_ack,
	input  cache_geom_pkg::word_t           i_dat,
	output logic                            o_cyc,
	output logic                            o_stb,
	output cache_geom_pkg::addr_t           o_adr,
	output logic                            o_word_we,
	output logic [$clog2(P_LINE_WORDS)-1:0] o_word_off,
	output cache_geom_pkg::word_t           o_word_dat,
	output logic                            o_done
);

	localparam int OFF_W = $clog2(P_LINE_WORDS);

	logic                  r_active, r_done;
	logic [OFF_W-1:0]      r_cnt;
	cache_geom_pkg::addr_t r_base;
	logic                  w_merge;

	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			r_active <= 1'b0;
			r_done   <= 1'b0;
			r_cnt    <= '0;
		end else begin
			r_done <= 1'b0;
			if (i_start) begin
				r_active <= 1'b1;
				r_cnt    <= '0;
			end else if (r_active && i_ack) begin
				r_cnt <= r_cnt + 1'b1;
				if (r_cnt == OFF_W'(P_LINE_WORDS - 1)) begin
					r_active <= 1'b0;
					r_done   <= 1'b1;
				end
			end
		end
	end

	always_ff @(posedge i_clk)
		if (i_start)
			r_base <= i_line_adr;

	// pending store bytes override the fetched word
	assign w_merge = i_pend_we && (i_pend_off == r_cnt);

	always_comb begin
		o_word_dat = i_dat;
		for (int b = 0; b < 4; b++)
			if (w_merge && i_pend_sel[b])
				o_word_dat[8*b +: 8] = i_pend_dat[8*b +: 8];
	end

	assign o_cyc      = r_active;
	assign o_stb      = r_active;
	assign o_adr      = r_base | {{(30-OFF_W){1'b0}}, r_cnt, 2'b00};
	assign o_word_we  = r_active && i_ack;
	assign o_word_off = r_cnt;
	assign o_done     = r_done;

	// a finished line leaves the counter back at word zero
	a_cnt_range: assert property (@(posedge i_clk) disable iff (i_rst)
		!r_active |-> r_cnt == '0);

endmodule

/* hw/cache_arrays.sv */
`timescale 1ns/1ps

module cache_arrays #(
	parameter int P_WAYS       = 4,
	parameter int P_LINE_WORDS = 8,
	parameter int P_SETS       = 64
) (
	input  logic                                  i_clk,
	input  logic [$clog2(P_SETS)-1:0]             i_index,
	input  logic [$clog2(P_WAYS)-1:0]             i_way,
	input  logic [$clog2(P_LINE_WORDS)-1:0]       i_offset,
	input  logic                                  i_tag_we,
	input  logic [31-$clog2(P_SETS)-$clog2(P_LINE_WORDS)-2:0] i_tag_wdat,
	input  logic                                  i_tag_valid,
	input  logic                                  i_data_we,
	input  cache_geom_pkg::sel_t                  i_data_sel,
	input  cache_geom_pkg::word_t                 i_data_wdat,
	input  logic                                  i_refill_we,
	input  logic [$clog2(P_LINE_WORDS)-1:0]       i_refill_off,
	input  cache_geom_pkg::word_t                 i_refill_dat,
	input  logic [31-$clog2(P_SETS)-$clog2(P_LINE_WORDS)-2:0] i_cmp_tag,
	output logic [P_WAYS-1:0]                     o_hit_way,
	output cache_geom_pkg::word_t                 o_rd_word,
	output logic                                  o_victim_valid,
	output logic [31-$clog2(P_SETS)-$clog2(P_LINE_WORDS)-2:0] o_victim_tag,
	output cache_geom_pkg::word_t                 o_victim_line [P_LINE_WORDS]
);

	localparam int OFF_W = $clog2(P_LINE_WORDS);
	localparam int IDX_W = $clog2(P_SETS);
	localparam int WAY_W = $clog2(P_WAYS);
	localparam int TAG_W = 32 - IDX_W - OFF_W - 2;

	logic [TAG_W-1:0]      r_tag_rd   [P_WAYS];
	logic                  r_valid_rd [P_WAYS];
	cache_geom_pkg::word_t r_line_rd  [P_WAYS][P_LINE_WORDS];
	logic [OFF_W-1:0]      r_off;
	logic [WAY_W-1:0]      w_rd_way;
	cache_geom_pkg::sel_t  w_wsel;
	cache_geom_pkg::word_t w_wdat;

	// refill and store hit never overlap
	assign w_wsel = i_refill_we ? 4'hf : i_data_sel;
	assign w_wdat = i_refill_we ? i_refill_dat : i_data_wdat;

	always_ff @(posedge i_clk)
		r_off <= i_offset;

	for (genvar w = 0; w < P_WAYS; w++) begin : g_way
		logic [TAG_W-1:0] tag_mem   [P_SETS];
		logic             valid_mem [P_SETS];
		logic             tag_wr;

		// an invalidating write clears every way of the set
		assign tag_wr = i_tag_we && (!i_tag_valid || i_way == WAY_W'(w));

		always_ff @(posedge i_clk) begin
			if (tag_wr) begin
				tag_mem[i_index]   <= i_tag_wdat;
				valid_mem[i_index] <= i_tag_valid;
			end
			r_tag_rd[w]   <= tag_mem[i_index];
			r_valid_rd[w] <= valid_mem[i_index];
		end

		assign o_hit_way[w] = r_valid_rd[w] && (r_tag_rd[w] == i_cmp_tag);

		for (genvar j = 0; j < P_LINE_WORDS; j++) begin : g_word
			cache_geom_pkg::word_t data_mem [P_SETS];
			logic                  word_wr;

			assign word_wr = (i_refill_we && i_way == WAY_W'(w) && i_refill_off == OFF_W'(j))
				|| (i_data_we && o_hit_way[w] && i_offset == OFF_W'(j));

			always_ff @(posedge i_clk) begin
				for (int b = 0; b < 4; b++)
					if (word_wr && w_wsel[b])
						data_mem[i_index][8*b +: 8] <= w_wdat[8*b +: 8];
				r_line_rd[w][j] <= data_mem[i_index];
			end
		end
	end

	// hitting way first, else the selected way
	always_comb begin
		w_rd_way = i_way;
		for (int w = 0; w < P_WAYS; w++)
			if (o_hit_way[w])
				w_rd_way = WAY_W'(w);
	end

	assign o_rd_word      = r_line_rd[w_rd_way][r_off];
	assign o_victim_valid = r_valid_rd[i_way];
	assign o_victim_tag   = r_tag_rd[i_way];
	assign o_victim_line  = r_line_rd[i_way];

endmodule

/* hw/dcache_ctrl.sv */
`timescale 1ns/1ps

module dcache_ctrl #(
	parameter int P_WAYS       = 4,
	parameter int P_LINE_WORDS = 8,
	parameter int P_SETS       = 64
) (
	input  logic                                  i_clk,
	input  logic                                  i_rst,
	input  logic                                  i_cpu_cyc,
	input  logic                                  i_cpu_stb,
	input  logic                                  i_cpu_we,
	input  cache_geom_pkg::sel_t                  i_cpu_sel,
	input  cache_geom_pkg::addr_t                 i_cpu_adr,
	input  cache_geom_pkg::word_t                 i_cpu_dat,
	input  logic [P_WAYS-1:0]                     i_tag_hit_way,
	input  logic                                  i_victim_valid,
	input  logic [31-$clog2(P_SETS)-$clog2(P_LINE_WORDS)-2:0] i_victim_tag,
	input  cache_geom_pkg::word_t                 i_rd_word,
	input  logic                                  i_refill_done,
	input  logic                                  i_wb_busy,
	output logic                                  o_cpu_ack,
	output cache_geom_pkg::word_t                 o_cpu_dat,
	output logic [$clog2(P_SETS)-1:0]             o_arr_index,
	output logic [$clog2(P_WAYS)-1:0]             o_arr_way,
	output logic                                  o_tag_we,
	output logic [31-$clog2(P_SETS)-$clog2(P_LINE_WORDS)-2:0] o_tag_wdat,
	output logic                                  o_tag_valid,
	output logic                                  o_hit_we,
	output logic                                  o_refill_start,
	output logic                                  o_wb_start,
	output cache_geom_pkg::addr_t                 o_line_adr,
	output cache_geom_pkg::addr_t                 o_victim_adr,
	output cache_geom_pkg::sel_t                  o_pend_sel,
	output cache_geom_pkg::word_t                 o_pend_dat
);

	localparam int OFF_W = $clog2(P_LINE_WORDS);
	localparam int IDX_W = $clog2(P_SETS);
	localparam int WAY_W = $clog2(P_WAYS);
	localparam int TAG_W = 32 - IDX_W - OFF_W - 2;
	localparam int LRU_W = P_WAYS - 1;

	cache_geom_pkg::ctrl_state_t r_state, w_state;
	logic [IDX_W-1:0] r_sweep;
	logic [IDX_W-1:0] w_index;
	logic [LRU_W-1:0] r_plru [P_SETS];
	logic [WAY_W-1:0] r_way, w_victim_way, w_hit_idx;
	logic             w_hit, r_refill_start;
	cache_geom_pkg::sel_t  r_pend_sel;
	cache_geom_pkg::word_t r_pend_dat;

	// tree pseudo-LRU, the bits point toward the older half
	function automatic logic [WAY_W-1:0] plru_victim(input logic [LRU_W-1:0] b);
		logic [2:0] pb;
		logic [1:0] v;
		pb = 3'(b);
		if (P_WAYS == 2)
			v = {1'b0, pb[0]};
		else
			v = {pb[0], pb[0] ? pb[2] : pb[1]};
		return WAY_W'(v);
	endfunction

	function automatic logic [LRU_W-1:0] plru_touch(input logic [LRU_W-1:0] b,
			input logic [WAY_W-1:0] w);
		logic [2:0] n;
		logic [1:0] pw;
		n  = 3'(b);
		pw = 2'(w);
		if (P_WAYS == 2) begin
			n[0] = ~pw[0];
		end else begin
			n[0] = ~pw[1];
			if (pw[1])
				n[2] = ~pw[0];
			else
				n[1] = ~pw[0];
		end
		return LRU_W'(n);
	endfunction

	assign w_index      = i_cpu_adr[IDX_W+OFF_W+1 : OFF_W+2];
	assign w_hit        = (r_state == cache_geom_pkg::LOOKUP) && (|i_tag_hit_way);
	assign w_victim_way = plru_victim(r_plru[w_index]);

	always_comb begin
		w_hit_idx = '0;
		for (int w = 0; w < P_WAYS; w++)
			if (i_tag_hit_way[w])
				w_hit_idx = w_hit_idx | WAY_W'(w);
	end

	always_comb begin
		w_state = r_state;
		case (r_state)
			cache_geom_pkg::INVALIDATING:
				if (r_sweep == IDX_W'(P_SETS - 1))
					w_state = cache_geom_pkg::IDLE;
			cache_geom_pkg::IDLE:
				if (i_cpu_cyc && i_cpu_stb)
					w_state = cache_geom_pkg::LOOKUP;
			cache_geom_pkg::LOOKUP:
				w_state = w_hit ? cache_geom_pkg::RESPOND : cache_geom_pkg::WAIT_WB;
			// previous victim must be out before this one is copied
			cache_geom_pkg::WAIT_WB:
				if (!i_wb_busy)
					w_state = cache_geom_pkg::REFILL;
			cache_geom_pkg::REFILL:
				if (i_refill_done)
					w_state = cache_geom_pkg::RESPOND;
			default:
				w_state = cache_geom_pkg::IDLE;
		endcase
	end

	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			r_state        <= cache_geom_pkg::INVALIDATING;
			r_sweep        <= '0;
			r_refill_start <= 1'b0;
		end else begin
			r_state        <= w_state;
			r_refill_start <= (r_state == cache_geom_pkg::WAIT_WB) && !i_wb_busy;
			if (r_state == cache_geom_pkg::INVALIDATING)
				r_sweep <= r_sweep + 1'b1;
		end
	end

	// victim way and pending store captured at the miss
	always_ff @(posedge i_clk) begin
		if (r_state == cache_geom_pkg::LOOKUP) begin
			r_way      <= w_victim_way;
			r_pend_sel <= i_cpu_we ? i_cpu_sel : '0;
			r_pend_dat <= i_cpu_dat;
		end
	end

	always_ff @(posedge i_clk) begin
		if (r_state == cache_geom_pkg::INVALIDATING)
			r_plru[r_sweep] <= '0;
		else if (w_hit)
			r_plru[w_index] <= plru_touch(r_plru[w_index], w_hit_idx);
		else if (r_state == cache_geom_pkg::REFILL && i_refill_done)
			r_plru[w_index] <= plru_touch(r_plru[w_index], r_way);
	end

	assign o_cpu_ack      = (r_state == cache_geom_pkg::RESPOND);
	assign o_cpu_dat      = i_rd_word;
	assign o_arr_index    = (r_state == cache_geom_pkg::INVALIDATING) ? r_sweep : w_index;
	assign o_arr_way      = (r_state == cache_geom_pkg::LOOKUP) ? w_victim_way : r_way;
	assign o_tag_valid    = (r_state != cache_geom_pkg::INVALIDATING);
	assign o_tag_we       = !o_tag_valid || (r_state == cache_geom_pkg::REFILL && i_refill_done);
	assign o_tag_wdat     = i_cpu_adr[31 -: TAG_W];
	assign o_hit_we       = w_hit && i_cpu_we;
	assign o_wb_start     = (r_state == cache_geom_pkg::WAIT_WB) && !i_wb_busy && i_victim_valid;
	assign o_refill_start = r_refill_start;
	assign o_line_adr     = {i_cpu_adr[31 : OFF_W+2], {(OFF_W+2){1'b0}}};
	assign o_victim_adr   = {i_victim_tag, w_index, {(OFF_W+2){1'b0}}};
	assign o_pend_sel     = r_pend_sel;
	assign o_pend_dat     = r_pend_dat;

	a_ack_needs_stb: assert property (@(posedge i_clk) disable iff (i_rst)
		o_cpu_ack |-> i_cpu_stb);
	// refill start is one cycle behind the write-back start
	a_one_start: assert property (@(posedge i_clk) disable iff (i_rst)
		!(o_wb_start && o_refill_start));

endmodule

/* hw/dcache_top.sv */
`timescale 1ns/1ps

module dcache_top #(
	parameter int P_WAYS       = 4,
	parameter int P_LINE_WORDS = 8,
	parameter int P_SETS       = 64
) (
	input  logic                  i_clk,
	input  logic                  i_rst,
	input  logic                  i_cpu_cyc,
	input  logic                  i_cpu_stb,
	input  logic                  i_cpu_we,
	input  cache_geom_pkg::sel_t  i_cpu_sel,
	input  cache_geom_pkg::addr_t i_cpu_adr,
	input  cache_geom_pkg::word_t i_cpu_dat,
	output cache_geom_pkg::word_t o_cpu_dat,
	output logic                  o_cpu_ack,
	output logic                  o_mem_cyc,
	output logic                  o_mem_stb,
	output logic                  o_mem_we,
	output cache_geom_pkg::sel_t  o_mem_sel,
	output cache_geom_pkg::addr_t o_mem_adr,
	output cache_geom_pkg::word_t o_mem_dat,
	input  cache_geom_pkg::word_t i_mem_dat,
	input  logic                  i_mem_ack
);

	localparam int OFF_W = $clog2(P_LINE_WORDS);
	localparam int IDX_W = $clog2(P_SETS);
	localparam int WAY_W = $clog2(P_WAYS);
	localparam int TAG_W = 32 - IDX_W - OFF_W - 2;

	logic [P_WAYS-1:0]     hit_way;
	logic                  victim_valid;
	logic [TAG_W-1:0]      victim_tag;
	cache_geom_pkg::word_t victim_line [P_LINE_WORDS];
	cache_geom_pkg::word_t rd_word;
	logic [IDX_W-1:0]      arr_index;
	logic [WAY_W-1:0]      arr_way;
	logic                  tag_we, tag_valid, hit_we;
	logic [TAG_W-1:0]      tag_wdat;
	logic                  refill_start, refill_done, wb_start, wb_busy;
	cache_geom_pkg::addr_t line_adr, victim_adr;
	cache_geom_pkg::sel_t  pend_sel;
	cache_geom_pkg::word_t pend_dat;

	// refill engine side
	logic                  rf_cyc, rf_stb, rf_ack, rf_word_we;
	cache_geom_pkg::addr_t rf_adr;
	logic [OFF_W-1:0]      rf_word_off;
	cache_geom_pkg::word_t rf_word_dat;

	// write-back engine side
	logic                  wb_cyc, wb_stb, wb_we, wb_ack;
	cache_geom_pkg::sel_t  wb_sel;
	cache_geom_pkg::addr_t wb_adr;
	cache_geom_pkg::word_t wb_dat;

	dcache_ctrl #(.P_WAYS(P_WAYS), .P_LINE_WORDS(P_LINE_WORDS), .P_SETS(P_SETS)) ctrl_i (
		.i_clk, .i_rst,
		.i_cpu_cyc, .i_cpu_stb, .i_cpu_we, .i_cpu_sel, .i_cpu_adr, .i_cpu_dat,
		.i_tag_hit_way(hit_way), .i_victim_valid(victim_valid), .i_victim_tag(victim_tag),
		.i_rd_word(rd_word), .i_refill_done(refill_done), .i_wb_busy(wb_busy),
		.o_cpu_ack, .o_cpu_dat,
		.o_arr_index(arr_index), .o_arr_way(arr_way), .o_tag_we(tag_we),
		.o_tag_wdat(tag_wdat), .o_tag_valid(tag_valid), .o_hit_we(hit_we),
		.o_refill_start(refill_start), .o_wb_start(wb_start),
		.o_line_adr(line_adr), .o_victim_adr(victim_adr),
		.o_pend_sel(pend_sel), .o_pend_dat(pend_dat)
	);

	cache_arrays #(.P_WAYS(P_WAYS), .P_LINE_WORDS(P_LINE_WORDS), .P_SETS(P_SETS)) arrays_i (
		.i_clk,
		.i_index(arr_index), .i_way(arr_way), .i_offset(i_cpu_adr[OFF_W+1:2]),
		.i_tag_we(tag_we), .i_tag_wdat(tag_wdat), .i_tag_valid(tag_valid),
		.i_data_we(hit_we), .i_data_sel(i_cpu_sel), .i_data_wdat(i_cpu_dat),
		.i_refill_we(rf_word_we), .i_refill_off(rf_word_off), .i_refill_dat(rf_word_dat),
		.i_cmp_tag(i_cpu_adr[31 -: TAG_W]),
		.o_hit_way(hit_way), .o_rd_word(rd_word), .o_victim_valid(victim_valid),
		.o_victim_tag(victim_tag), .o_victim_line(victim_line)
	);

	line_refill #(.P_LINE_WORDS(P_LINE_WORDS)) refill_i (
		.i_clk, .i_rst,
		.i_start(refill_start), .i_line_adr(line_adr),
		.i_pend_we(i_cpu_we), .i_pend_off(i_cpu_adr[OFF_W+1:2]),
		.i_pend_sel(pend_sel), .i_pend_dat(pend_dat),
		.i_ack(rf_ack), .i_dat(i_mem_dat),
		.o_cyc(rf_cyc), .o_stb(rf_stb), .o_adr(rf_adr),
		.o_word_we(rf_word_we), .o_word_off(rf_word_off), .o_word_dat(rf_word_dat),
		.o_done(refill_done)
	);

	line_writeback #(.P_LINE_WORDS(P_LINE_WORDS)) wback_i (
		.i_clk, .i_rst,
		.i_start(wb_start), .i_victim_adr(victim_adr), .i_victim_line(victim_line),
		.i_ack(wb_ack),
		.o_cyc(wb_cyc), .o_stb(wb_stb), .o_we(wb_we), .o_sel(wb_sel),
		.o_adr(wb_adr), .o_dat(wb_dat), .o_busy(wb_busy)
	);

	wb_arbiter arb_i (
		.i_clk, .i_rst,
		.i_wb_cyc(wb_cyc), .i_wb_stb(wb_stb), .i_wb_we(wb_we), .i_wb_sel(wb_sel),
		.i_wb_adr(wb_adr), .i_wb_dat(wb_dat),
		.i_rf_cyc(rf_cyc), .i_rf_stb(rf_stb), .i_rf_adr(rf_adr),
		.i_mem_ack,
		.o_grant(), .o_mem_cyc, .o_mem_stb, .o_mem_we, .o_mem_sel,
		.o_mem_adr, .o_mem_dat,
		.o_ack_wb(wb_ack), .o_ack_refill(rf_ack)
	);

endmodule

/* dv/wb_mem_model.sv */
`timescale 1ns/1ps

module wb_mem_model #(
	parameter cache_geom_pkg::word_t P_FILL = 32'h0,
	parameter logic [31:0]           P_SEED = 32'h1
) (
	input  logic                  i_clk,
	input  logic                  i_rst,
	input  logic                  i_cyc,
	input  logic                  i_stb,
	input  logic                  i_we,
	input  cache_geom_pkg::sel_t  i_sel,
	input  cache_geom_pkg::addr_t i_adr,
	input  cache_geom_pkg::word_t i_dat,
	output cache_geom_pkg::word_t o_dat,
	output logic                  o_ack,
	output logic                  o_log_valid,
	output cache_geom_pkg::addr_t o_log_adr,
	output cache_geom_pkg::word_t o_log_dat
);

	localparam logic [31:0] TAPS = 32'h8020_0003;

	cache_geom_pkg::word_t mem [cache_geom_pkg::addr_t];
	logic [31:0] r_lfsr;
	logic [1:0]  r_wait;

	function automatic logic [31:0] lfsr_shift(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ TAPS) : (s >> 1);
	endfunction

	// untouched words hold the fill pattern
	function automatic cache_geom_pkg::word_t stored_word(input cache_geom_pkg::addr_t key);
		if (mem.exists(key))
			return mem[key];
		return key ^ P_FILL;
	endfunction

	always @(posedge i_clk) begin
		cache_geom_pkg::addr_t key;
		cache_geom_pkg::word_t w;
		logic [31:0]           s;
		logic [1:0]            d;
		key = {i_adr[31:2], 2'b00};
		if (i_rst) begin
			o_ack       <= 1'b0;
			o_log_valid <= 1'b0;
			r_wait      <= '0;
			r_lfsr      <= P_SEED;
		end else begin
			o_ack       <= 1'b0;
			o_log_valid <= 1'b0;
			if (i_cyc && i_stb && !o_ack) begin
				if (r_wait != 2'd0) begin
					r_wait <= r_wait - 1'b1;
				end else begin
					// wait before the next ack, one lfsr step per bit
					s = r_lfsr;
					d = '0;
					for (int k = 0; k < 2; k++) begin
						d = {d[0], s[0]};
						s = lfsr_shift(s);
					end
					r_lfsr <= s;
					r_wait <= d;
					o_ack  <= 1'b1;
					w = stored_word(key);
					if (i_we) begin
						for (int b = 0; b < 4; b++)
							if (i_sel[b])
								w[8*b +: 8] = i_dat[8*b +: 8];
						mem[key] = w;
						o_log_valid <= 1'b1;
						o_log_adr   <= key;
						o_log_dat   <= w;
					end
					o_dat <= w;
				end
			end
		end
	end

endmodule

/* dv/tb_dcache.sv */
`timescale 1ns/1ps

module tb_dcache;

	localparam int WAYS       = cache_geom_pkg::WAYS_DEFAULT;
	localparam int LINE_WORDS = cache_geom_pkg::LINE_WORDS_DEFAULT;
	localparam int SETS       = cache_geom_pkg::SETS_DEFAULT;
	localparam int LINE_BYTES = 4 * LINE_WORDS;
	localparam int SET_STRIDE = LINE_BYTES * SETS;
	localparam int PERIOD     = 40;
	localparam int N_RANDOM   = 300;
	localparam int N_OPS      = SETS + 32 + N_RANDOM;
	// write-back plus refill, up to 6 cycles per word, plus FSM overhead
	localparam int MISS_CYCLES  = 2 * LINE_WORDS * 6 + 12;
	localparam int LIMIT_CYCLES = 16 + SETS + N_OPS * MISS_CYCLES;
	localparam logic [31:0]           SEED      = 32'h1a56_00a9;
	localparam logic [31:0]           TAPS      = 32'h8020_0003;
	localparam cache_geom_pkg::word_t FILL      = 32'h5a3c_96e1;
	localparam cache_geom_pkg::addr_t BASE      = 32'h0001_0000;
	localparam cache_geom_pkg::addr_t RAND_BASE = 32'h0008_0000;
	localparam cache_geom_pkg::addr_t LINE_MASK = ~cache_geom_pkg::addr_t'(LINE_BYTES - 1);

	logic i_clk;
	logic i_rst;
	logic cpu_cyc, cpu_stb, cpu_we, cpu_ack;
	cache_geom_pkg::sel_t  cpu_sel;
	cache_geom_pkg::addr_t cpu_adr;
	cache_geom_pkg::word_t cpu_dat, cpu_rdat;
	logic mem_cyc, mem_stb, mem_we, mem_ack, log_valid;
	cache_geom_pkg::sel_t  mem_sel;
	cache_geom_pkg::addr_t mem_adr, log_adr, cur_line;
	cache_geom_pkg::word_t mem_wdat, mem_rdat, log_dat;

	cache_geom_pkg::word_t ref_mem [cache_geom_pkg::addr_t];
	bit                    filled  [cache_geom_pkg::addr_t];
	cache_geom_pkg::word_t exp_q [$];
	logic                  exp_rd_q [$];
	cache_geom_pkg::word_t cmp_exp;
	logic                  cmp_rd;
	logic [31:0]           lfsr_state;
	int errors, checks, n_mem_reads, n_mem_cycles, n_writes;

	dcache_top #(.P_WAYS(WAYS), .P_LINE_WORDS(LINE_WORDS), .P_SETS(SETS)) dut_i (
		.i_clk(i_clk), .i_rst(i_rst),
		.i_cpu_cyc(cpu_cyc), .i_cpu_stb(cpu_stb), .i_cpu_we(cpu_we), .i_cpu_sel(cpu_sel),
		.i_cpu_adr(cpu_adr), .i_cpu_dat(cpu_dat), .o_cpu_dat(cpu_rdat), .o_cpu_ack(cpu_ack),
		.o_mem_cyc(mem_cyc), .o_mem_stb(mem_stb), .o_mem_we(mem_we), .o_mem_sel(mem_sel),
		.o_mem_adr(mem_adr), .o_mem_dat(mem_wdat), .i_mem_dat(mem_rdat), .i_mem_ack(mem_ack)
	);

	wb_mem_model #(.P_FILL(FILL), .P_SEED(SEED)) mem_i (
		.i_clk(i_clk), .i_rst(i_rst),
		.i_cyc(mem_cyc), .i_stb(mem_stb), .i_we(mem_we), .i_sel(mem_sel),
		.i_adr(mem_adr), .i_dat(mem_wdat), .o_dat(mem_rdat), .o_ack(mem_ack),
		.o_log_valid(log_valid), .o_log_adr(log_adr), .o_log_dat(log_dat)
	);

	initial i_clk = 1'b0;
	always #(PERIOD / 2) i_clk = ~i_clk;

	// galois lfsr, one step per bit taken
	function automatic logic [31:0] random_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int k = 0; k < n; k++) begin
			v = {v[30:0], lfsr_state[0]};
			lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ TAPS) : (lfsr_state >> 1);
		end
		return v;
	endfunction

	function automatic cache_geom_pkg::word_t ref_read(input cache_geom_pkg::addr_t adr);
		cache_geom_pkg::addr_t key;
		key = {adr[31:2], 2'b00};
		if (ref_mem.exists(key))
			return ref_mem[key];
		return key ^ FILL;
	endfunction

	// expected word after the access, stores merged byte by byte
	function automatic cache_geom_pkg::word_t ref_access(input cache_geom_pkg::addr_t adr,
			input logic we, input cache_geom_pkg::sel_t sel, input cache_geom_pkg::word_t dat);
		cache_geom_pkg::word_t w;
		w = ref_read(adr);
		if (we) begin
			for (int b = 0; b < 4; b++)
				if (sel[b])
					w[8*b +: 8] = dat[8*b +: 8];
			ref_mem[{adr[31:2], 2'b00}] = w;
		end
		return w;
	endfunction

	task automatic check_word(input string name, input cache_geom_pkg::word_t got,
			input cache_geom_pkg::word_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("ERR t=%0t %s got=%h exp=%h", $time, name, got, exp);
		end
	endtask

	task automatic check_addr(input string name, input cache_geom_pkg::addr_t got,
			input cache_geom_pkg::addr_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("ERR t=%0t %s got=%h exp=%h", $time, name, got, exp);
		end
	endtask

	task automatic check_count(input string what, input int got, input int exp);
		checks++;
		if (got != exp) begin
			errors++;
			$display("at %0t the %s was %0d where %0d was expected", $time, what, got, exp);
		end
	endtask

	// one processor access, held until the ack is sampled
	task automatic cpu_access(input cache_geom_pkg::addr_t adr, input logic we,
			input cache_geom_pkg::sel_t sel, input cache_geom_pkg::word_t dat,
			output int lat, output int reads, output int bus_cycles);
		int reads0, cycles0;
		exp_q.push_back(ref_access(adr, we, sel, dat));
		exp_rd_q.push_back(!we);
		@(negedge i_clk);
		cur_line = adr & LINE_MASK;
		reads0   = n_mem_reads;
		cycles0  = n_mem_cycles;
		cpu_cyc  = 1'b1;
		cpu_stb  = 1'b1;
		cpu_we   = we;
		cpu_sel  = sel;
		cpu_adr  = adr;
		cpu_dat  = dat;
		lat = 0;
		do begin
			@(negedge i_clk);
			lat++;
		end while (!cpu_ack);
		reads      = n_mem_reads - reads0;
		bus_cycles = n_mem_cycles - cycles0;
		@(posedge i_clk);
		@(negedge i_clk);
		cpu_cyc = 1'b0;
		cpu_stb = 1'b0;
		cpu_we  = 1'b0;
	endtask

	task automatic report_test(input int num, input string what, input int errs_before);
		if (errors == errs_before)
			$display("test %0d %s: ok", num, what);
		else
			$display("test %0d %s: %0d errors", num, what, errors - errs_before);
	endtask

	// every ack is checked against the reference, read data only
	always @(negedge i_clk) begin
		if (!i_rst && cpu_ack) begin
			if (exp_q.size() == 0) begin
				errors++;
				$display("at %0t an ack arrived with no access outstanding", $time);
			end else begin
				cmp_exp = exp_q.pop_front();
				cmp_rd  = exp_rd_q.pop_front();
				if (cmp_rd)
					check_word("o_cpu_dat", cpu_rdat, cmp_exp);
			end
		end
	end

	// memory bus monitor
	always @(negedge i_clk) begin
		if (!i_rst) begin
			if (mem_cyc)
				n_mem_cycles++;
			if (mem_cyc && mem_stb && mem_ack && !mem_we) begin
				n_mem_reads++;
				filled[mem_adr & LINE_MASK] = 1'b1;
				check_addr("o_mem_adr line", mem_adr & LINE_MASK, cur_line);
			end
			if (log_valid) begin
				n_writes++;
				if (!filled.exists(log_adr & LINE_MASK)) begin
					errors++;
					$display("at %0t memory was written in line %h that was never filled",
						$time, log_adr & LINE_MASK);
				end
				check_word("memory write data", log_dat, ref_read(log_adr));
			end
		end
	end

	initial begin
		#(LIMIT_CYCLES * PERIOD);
		$display("watchdog expired after %0d cycles, the DUT stopped responding", LIMIT_CYCLES);
		$display("*** FAILED ***");
		$finish;
	end

	initial begin
		cache_geom_pkg::addr_t adr;
		int lat, reads, bus_cycles, mark;
		cpu_cyc      = 1'b0;
		cpu_stb      = 1'b0;
		cpu_we       = 1'b0;
		cpu_sel      = '0;
		cpu_adr      = '0;
		cpu_dat      = '0;
		cur_line     = '0;
		lfsr_state   = SEED;
		errors       = 0;
		checks       = 0;
		n_mem_reads  = 0;
		n_mem_cycles = 0;
		n_writes     = 0;
		i_rst        = 1'b1;
		repeat (16) @(negedge i_clk);
		i_rst = 1'b0;

		mark = errors;
		for (int s = 0; s < SETS; s++) begin
			adr = BASE + s * LINE_BYTES + (s % LINE_WORDS) * 4;
			cpu_access(adr, 1'b0, 4'hf, '0, lat, reads, bus_cycles);
		end
		report_test(1, "reads across all sets", mark);

		mark = errors;
		adr = BASE + 5 * LINE_BYTES + 8;
		cpu_access(adr, 1'b1, 4'b0101, 32'hdead_beef, lat, reads, bus_cycles);
		check_count("number of memory reads for a store hit", reads, 0);
		cpu_access(adr, 1'b0, 4'hf, '0, lat, reads, bus_cycles);
		adr = BASE + 2 * SET_STRIDE + 7 * LINE_BYTES + 4;
		cpu_access(adr, 1'b1, 4'b1100, 32'h1234_5678, lat, reads, bus_cycles);
		check_count("number of memory reads for a store miss", reads, LINE_WORDS);
		cpu_access(adr, 1'b0, 4'hf, '0, lat, reads, bus_cycles);
		report_test(2, "partial stores on hit and miss", mark);

		mark = errors;
		adr = BASE + 9 * LINE_BYTES + 12;
		cpu_access(adr, 1'b0, 4'hf, '0, lat, reads, bus_cycles);
		cpu_access(adr, 1'b0, 4'hf, '0, lat, reads, bus_cycles);
		check_count("hit latency in cycles", lat, 2);
		check_count("number of memory bus cycles on a hit", bus_cycles, 0);
		report_test(3, "hit latency", mark);

		// five lines in set 20, the first touched again before the fifth
		mark = errors;
		for (int k = 1; k <= 4; k++) begin
			adr = BASE + 20 * LINE_BYTES + k * SET_STRIDE;
			cpu_access(adr, 1'b0, 4'hf, '0, lat, reads, bus_cycles);
		end
		adr = BASE + 20 * LINE_BYTES + SET_STRIDE + 4;
		cpu_access(adr, 1'b0, 4'hf, '0, lat, reads, bus_cycles);
		adr = BASE + 20 * LINE_BYTES + 5 * SET_STRIDE;
		cpu_access(adr, 1'b0, 4'hf, '0, lat, reads, bus_cycles);
		adr = BASE + 20 * LINE_BYTES + SET_STRIDE + 8;
		cpu_access(adr, 1'b0, 4'hf, '0, lat, reads, bus_cycles);
		check_count("number of memory reads for the recently used line", reads, 0);
		for (int k = 1; k <= 5; k++) begin
			adr = BASE + 20 * LINE_BYTES + k * SET_STRIDE + ((3 * k) % LINE_WORDS) * 4;
			cpu_access(adr, 1'b0, 4'hf, '0, lat, reads, bus_cycles);
		end
		report_test(4, "pseudo-LRU keeps the recent line", mark);

		mark = errors;
		for (int k = 0; k < N_RANDOM; k++) begin
			cache_geom_pkg::sel_t  sel;
			cache_geom_pkg::word_t dat;
			logic                  we;
			int                    tag, set, word;
			tag  = int'(random_bits(3));
			set  = int'(random_bits(2));
			word = int'(random_bits(3));
			we   = 1'(random_bits(1));
			sel  = 4'(random_bits(4));
			dat  = random_bits(32);
			adr  = RAND_BASE + tag * SET_STRIDE + set * LINE_BYTES + word * 4;
			cpu_access(adr, we, sel, dat, lat, reads, bus_cycles);
		end
		report_test(6, "random mix with ack delays", mark);

		mark = errors;
		if (n_writes == 0) begin
			errors++;
			$display("no write-back reached memory during the run");
		end
		report_test(5, "write-back lines and data", mark);

		$display("tests done, %0d checks, %0d memory writes, %0d errors",
			checks, n_writes, errors);
		if (errors == 0)
			$display("*** PASSED ***");
		else
			$display("*** FAILED ***");
		$finish;
	end

endmodule

/* compile.f */
hw/cache_geom_pkg.sv
hw/wb_bus_pkg.sv
hw/wb_arbiter.sv
hw/line_writeback.sv
hw/line_refill.sv
hw/cache_arrays.sv
hw/dcache_ctrl.sv
hw/dcache_top.sv
dv/wb_mem_model.sv
dv/tb_dcache.sv

/* run_sim.sh */
#!/bin/sh
# build the testbench with Verilator, run it, and scan the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module tb_dcache -Mdir obj_dir -f compile.f
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/Vtb_dcache > sim.log 2>&1
run_status=$?
cat sim.log
if [ $run_status -ne 0 ]; then
	echo "simulation exited with status $run_status"
	exit 1
fi

if grep -q '\*\*\* FAILED \*\*\*' sim.log; then
	echo "simulation reported a failure"
	exit 1
fi
exit 0
